/* common/claPkg.sv */
package claPkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int dataWidth  = 16;
    localparam int busWidth   = 32;
    localparam int addrWidth  = 5;
    localparam int groupCount = dataWidth / 4;  // Lookahead groups of four bits

    // ========================================================================
    // Register map
    // ========================================================================
    localparam logic [addrWidth-1:0] addrOpA    = 5'h00;
    localparam logic [addrWidth-1:0] addrOpB    = 5'h04;
    localparam logic [addrWidth-1:0] addrCtrl   = 5'h08;
    localparam logic [addrWidth-1:0] addrResult = 5'h0C;
    localparam logic [addrWidth-1:0] addrCount  = 5'h10;

    localparam int ctrlSubBit   = 0;
    localparam int ctrlCinBit   = 1;
    localparam int ctrlStartBit = 2;  // Self clearing, always reads as 0

    localparam int resCarryBit = 16;
    localparam int resOvfBit   = 17;
    localparam int resZeroBit  = 18;
    localparam int resNegBit   = 19;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

endpackage

/* adder/claCarryTree.sv */
module claCarryTree import claPkg::*; (
    input  logic                 cin,
    input  logic [dataWidth-1:0] pIn,
    input  logic [dataWidth-1:0] gIn,
    output logic [dataWidth-1:0] cOut,
    output logic                 pOut,
    output logic                 gOut
);

    // Carries into each of four bits, lowest carry is the incoming one
    function automatic logic [3:0] laCarry(
        input logic       c,
        input logic [3:0] p,
        input logic [3:0] g
    );
        return {g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c),
                g[1] | (p[1] & g[0]) | (p[1] & p[0] & c),
                g[0] | (p[0] & c),
                c};
    endfunction

    // Group generate in the upper bit, group propagate in the lower
    function automatic logic [1:0] laGroup(
        input logic [3:0] p,
        input logic [3:0] g
    );
        logic gen;
        gen = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
        return {gen, &p};
    endfunction

    logic [groupCount-1:0] groupP;
    logic [groupCount-1:0] groupG;
    logic [groupCount-1:0] groupCin;

    // ========================================================================
    // First level: four 4-bit groups
    // ========================================================================
    for (genvar i = 0; i < groupCount; i++) begin : genGroup
        assign cOut[4*i +: 4] = laCarry(groupCin[i], pIn[4*i +: 4], gIn[4*i +: 4]);
        assign {groupG[i], groupP[i]} = laGroup(pIn[4*i +: 4], gIn[4*i +: 4]);
    end

    // ========================================================================
    // Second level across the groups
    // ========================================================================
    assign groupCin     = laCarry(cin, groupP, groupG);
    assign {gOut, pOut} = laGroup(groupP, groupG);

endmodule

/* adder/claAdder16.sv */
module claAdder16 import claPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 sub,
    input  logic                 cin,
    output logic [dataWidth-1:0] sum,
    output logic                 carryOut,
    output logic                 overflow
);

    logic [dataWidth-1:0] bEff;
    logic [dataWidth-1:0] prop;
    logic [dataWidth-1:0] gen;
    logic [dataWidth-1:0] carry;
    logic                 cinEff;
    logic                 blockP;
    logic                 blockG;

    // Two's complement subtract adds the inverted operand plus one
    assign bEff   = sub ? ~b : b;
    assign cinEff = sub | cin;  // Carry-in is forced when subtracting

    for (genvar i = 0; i < dataWidth; i++) begin : genBit
        assign prop[i] = a[i] | bEff[i];
        assign gen[i]  = a[i] & bEff[i];
        assign sum[i]  = a[i] ^ bEff[i] ^ carry[i];
    end

    claCarryTree uTree (
        .cin  (cinEff),
        .pIn  (prop),
        .gIn  (gen),
        .cOut (carry),
        .pOut (blockP),
        .gOut (blockG)
    );

    assign carryOut = blockG | (blockP & cinEff);
    assign overflow = carry[dataWidth-1] ^ carryOut;  // Sign carry-in differs from carry-out

endmodule

/* source/flagUnit.sv */
module flagUnit import claPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic [dataWidth-1:0] sum,
    input  logic                 carryOut,
    input  logic                 overflow,
    output logic [busWidth-1:0]  resultWord,
    output logic [busWidth-1:0]  opCount
);

    logic [busWidth-1:0] nextWord;

    always_comb begin
        nextWord                  = '0;
        nextWord[dataWidth-1:0]   = sum;
        nextWord[resCarryBit]     = carryOut;
        nextWord[resOvfBit]       = overflow;
        nextWord[resZeroBit]      = ~|sum;
        nextWord[resNegBit]       = sum[dataWidth-1];  // Sign of the result
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultWord <= '0;
            opCount    <= '0;
        end else if (start) begin
            resultWord <= nextWord;
            opCount    <= opCount + 1'b1;  // Wraps after all ones
        end
    end

endmodule

/* source/axiLiteRegs.sv */
module axiLiteRegs import claPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [addrWidth-1:0] awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [busWidth-1:0]  wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [addrWidth-1:0] araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [busWidth-1:0]  rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready,
    input  logic [busWidth-1:0]  resultWord,
    input  logic [busWidth-1:0]  opCount,
    output logic [dataWidth-1:0] opA,
    output logic [dataWidth-1:0] opB,
    output logic                 sub,
    output logic                 cin,
    output logic                 start
);

    logic                wrReady;
    logic                wrFire;
    logic                wrMapped;
    logic                rdFire;
    logic                rdMapped;
    logic [busWidth-1:0] rdMux;

    // ========================================================================
    // Write channel
    // ========================================================================
    assign awready  = wrReady;
    assign wready   = wrReady;  // Address and data are taken together
    assign wrFire   = wrReady & awvalid & wvalid;
    assign wrMapped = (awaddr == addrOpA) || (awaddr == addrOpB) || (awaddr == addrCtrl) ||
                      (awaddr == addrResult) || (awaddr == addrCount);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrReady <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= respOkay;
        end else if (wrFire) begin
            wrReady <= 1'b0;
            bvalid  <= 1'b1;
            bresp   <= wrMapped ? respOkay : respSlvErr;
        end else if (bvalid) begin
            if (bready) begin
                bvalid <= 1'b0;  // Ready drops for a cycle before the next write
            end
        end else begin
            wrReady <= awvalid & wvalid;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opA   <= '0;
            opB   <= '0;
            sub   <= 1'b0;
            cin   <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wrFire) begin
                case (awaddr)
                    addrOpA: opA <= wdata[dataWidth-1:0];
                    addrOpB: opB <= wdata[dataWidth-1:0];
                    addrCtrl: begin
                        sub   <= wdata[ctrlSubBit];
                        cin   <= wdata[ctrlCinBit];
                        start <= wdata[ctrlStartBit];  // One cycle pulse
                    end
                    default: ;  // Result and count are read only
                endcase
            end
        end
    end

    // ========================================================================
    // Read channel
    // ========================================================================
    assign rdFire = arready & arvalid;

    always_comb begin
        rdMux    = '0;
        rdMapped = 1'b1;
        case (araddr)
            addrOpA:    rdMux[dataWidth-1:0] = opA;
            addrOpB:    rdMux[dataWidth-1:0] = opB;
            addrCtrl: begin
                rdMux[ctrlSubBit] = sub;
                rdMux[ctrlCinBit] = cin;
            end
            addrResult: rdMux = resultWord;
            addrCount:  rdMux = opCount;
            default:    rdMapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= respOkay;
        end else if (rdFire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= rdMux;
            rresp   <= rdMapped ? respOkay : respSlvErr;
        end else if (rvalid) begin
            if (rready) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
        end else begin
            arready <= 1'b1;  // Idle and nothing pending
        end
    end

endmodule

/* source/claAccelTop.sv */
module claAccelTop import claPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [addrWidth-1:0] awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [busWidth-1:0]  wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  logic [addrWidth-1:0] araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic [busWidth-1:0]  rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic                 sub;
    logic                 cin;
    logic                 start;
    logic [dataWidth-1:0] sum;
    logic                 carryOut;
    logic                 overflow;
    logic [busWidth-1:0]  resultWord;
    logic [busWidth-1:0]  opCount;

    axiLiteRegs uRegs (
        .clk        (clk),
        .rstN       (rstN),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .resultWord (resultWord),
        .opCount    (opCount),
        .opA        (opA),
        .opB        (opB),
        .sub        (sub),
        .cin        (cin),
        .start      (start)
    );

    claAdder16 uAdder (
        .a        (opA),
        .b        (opB),
        .sub      (sub),
        .cin      (cin),
        .sum      (sum),
        .carryOut (carryOut),
        .overflow (overflow)
    );

    flagUnit uFlags (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .sum        (sum),
        .carryOut   (carryOut),
        .overflow   (overflow),
        .resultWord (resultWord),
        .opCount    (opCount)
    );

endmodule

/* sim/claAccelAssertions.sv */
module claAccelAssertions (
    input logic clk,
    input logic rstN,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic start
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;  // Number of failed assertions

    bHold: assert property (@(posedge clk) disable iff (!rstN) bvalid && !bready |=> bvalid)
        else begin
            failCount++;
            $error("bvalid dropped before bready");
        end

    rHold: assert property (@(posedge clk) disable iff (!rstN) rvalid && !rready |=> rvalid)
        else begin
            failCount++;
            $error("rvalid dropped before rready");
        end

    // Write back-pressure while a response waits
    wrBlocked: assert property (@(posedge clk) disable iff (!rstN) bvalid |-> !awready && !wready)
        else begin
            failCount++;
            $error("awready or wready high while bvalid is pending");
        end

    startPulse: assert property (@(posedge clk) disable iff (!rstN) start |=> !start)
        else begin
            failCount++;
            $error("start lasted longer than one cycle");
        end

    resetQuiet: assert property (@(posedge clk) $rose(rstN) |->
                                 !awready && !wready && !bvalid && !arready && !rvalid && !start)
        else begin
            failCount++;
            $error("handshake outputs not low at reset release");
        end

endmodule

bind axiLiteRegs claAccelAssertions uAsserts (.*);

/* sim/claAccelTb.sv */
module claAccelTb import claPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic                 sub;
        logic                 cin;
        logic [busWidth-1:0]  expected;
    } vecT;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic [addrWidth-1:0] awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [busWidth-1:0]  wdata;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [addrWidth-1:0] araddr;
    logic                 arvalid;
    logic                 arready;
    logic [busWidth-1:0]  rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;

    vecT    vecs[$];
    integer seed       = 32'hc602dd54;
    int     errorCount = 0;
    int     cycleCount = 0;
    int     cycleLimit = 200;

    claAccelTop dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // ========================================================================
    // AXI4-Lite master transfers with random response back-pressure
    // ========================================================================
    task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [busWidth-1:0] data,
                            output logic [1:0] resp);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);  // Transfer edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic readReg(input logic [addrWidth-1:0] addr, output logic [busWidth-1:0] data,
                           output logic [1:0] resp);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    initial begin
        int                  fd;
        string               line;
        logic [31:0]         fa;
        logic [31:0]         fb;
        logic [31:0]         fs;
        logic [31:0]         fc;
        logic [31:0]         fe;
        vecT                 v;
        logic [busWidth-1:0] ctrl;
        logic [busWidth-1:0] rd;
        logic [busWidth-1:0] lastResult;
        logic [1:0]          resp;
        int                  assertFails;

        rstN    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lastResult = '0;

        fd = $fopen("sim/claStimulus.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file sim/claStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == "#") continue;  // Skip comments
                if ($sscanf(line, "%h %h %h %h %h", fa, fb, fs, fc, fe) == 5) begin
                    v = '{fa[15:0], fb[15:0], fs[0], fc[0], fe};
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
        cycleLimit = 40 * vecs.size() + 200;

        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        readReg(addrResult, rd, resp);
        checkValue(rd, 32'h0, "result after reset");
        readReg(addrCount, rd, resp);
        checkValue(rd, 32'h0, "count after reset");

        // ====================================================================
        // Additions and subtractions from the stimulus file
        // ====================================================================
        foreach (vecs[i]) begin
            v = vecs[i];
            writeReg(addrOpA, {16'h0, v.a}, resp);
            writeReg(addrOpB, {16'h0, v.b}, resp);
            ctrl               = '0;
            ctrl[ctrlStartBit] = 1'b1;
            ctrl[ctrlCinBit]   = v.cin;
            ctrl[ctrlSubBit]   = v.sub;
            writeReg(addrCtrl, ctrl, resp);
            checkValue(32'(resp), 32'(respOkay), $sformatf("control write resp, line %0d", i));
            readReg(addrOpA, rd, resp);
            checkValue(rd, {16'h0, v.a}, $sformatf("operand A read back, line %0d", i));
            readReg(addrOpB, rd, resp);
            checkValue(rd, {16'h0, v.b}, $sformatf("operand B read back, line %0d", i));
            readReg(addrResult, rd, resp);
            checkValue(rd, v.expected, $sformatf("result word, line %0d", i));
            checkValue(32'(resp), 32'(respOkay), $sformatf("result read resp, line %0d", i));
            lastResult = v.expected;
        end

        // Control write without start leaves result and count alone
        readReg(addrCount, rd, resp);
        checkValue(rd, 32'(vecs.size()), "operation count");
        writeReg(addrCtrl, 32'h3, resp);
        readReg(addrCtrl, rd, resp);
        checkValue(rd, 32'h3, "control read back");
        readReg(addrResult, rd, resp);
        checkValue(rd, lastResult, "result after control write without start");
        readReg(addrCount, rd, resp);
        checkValue(rd, 32'(vecs.size()), "count after control write without start");

        writeReg(5'h14, 32'hdeadbeef, resp);
        checkValue(32'(resp), 32'(respSlvErr), "unmapped write resp");
        readReg(5'h14, rd, resp);
        checkValue(32'(resp), 32'(respSlvErr), "unmapped read resp");
        checkValue(rd, 32'h0, "unmapped read data");

        assertFails = dut0.uRegs.uAsserts.failCount;
        $display("Run finished with %0d check errors and %0d assertion failures",
                 errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/claStimulus.txt */
# Columns (hex): operand A, operand B, subtract, carry-in, expected result word
# Result word: bit 19 negative, 18 zero, 17 overflow, 16 carry, bits 15:0 sum
0001 0001 0 0 00000002
ffff 0001 0 0 00050000
ffff 0000 0 1 00050000
7fff 0001 0 0 000a8000
8000 8000 0 0 00070000
1234 4321 0 1 00005556
ffff ffff 0 1 0009ffff
00ff 0f01 0 0 00001000
a5a5 5a5a 0 0 0008ffff
0005 0003 1 0 00010002
0003 0005 1 0 0008fffe
1234 1234 1 0 00050000
8000 0001 1 0 00037fff
7fff ffff 1 1 000a8000
0000 0001 1 0 0008ffff
0000 0000 1 0 00050000
0000 0000 0 0 00040000

/* compile.f */
common/claPkg.sv
adder/claCarryTree.sv
adder/claAdder16.sv
source/flagUnit.sv
source/axiLiteRegs.sv
source/claAccelTop.sv
sim/claAccelAssertions.sv
sim/claAccelTb.sv

/* Makefile */
# Verilator flow for the CLA accelerator

VERILATOR  ?= verilator
TOP        ?= claAccelTb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= \*\* PASS \*\*

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
